// File: rtl/obj_pkg.sv
// Shared constants and types for the sprite line renderer
// One line half covers 256 pixel slots, so sprite x wraps modulo 256
// A pixel word is {palette[3:0], colour index[3:0]}
// Colour index 15 is transparent and is never written to the buffer
// The blank word also carries index 15, so erased slots read as transparent

package obj_pkg;

    // Buffer address width for one line half
    localparam int obj_aw = 8;

    // Pixel word width, palette in the upper nibble
    localparam int obj_dw = 8;

    // Visible pixel slots per line
    localparam int obj_h_active = 256;

    // Pixel slots per line including blanking
    localparam int obj_h_total = 320;

    // Transparent colour index
    localparam logic [3:0] obj_alpha = 4'hf;

    // Erase value, all ones
    localparam logic [obj_dw-1:0] obj_blank = {obj_dw{1'b1}};

    // Pixels in one sprite row
    localparam int obj_row_pixels = 8;

    // Draw stage states
    typedef enum logic {
        draw_idle,
        draw_busy
    } obj_draw_state_t;

endpackage

// File: rtl/obj_dual_ram.sv
// Two-port synchronous RAM holding both line halves
// Port 0 only writes, port 1 reads and writes
// q1 is registered and returns the old word on a port 1 write
// If both ports write one address in a cycle, port 1 wins

`timescale 1ns/10ps

module obj_dual_ram (
    input  logic                        clk,
    input  logic [obj_pkg::obj_aw:0]    addr0,
    input  logic [obj_pkg::obj_dw-1:0]  data0,
    input  logic                        we0,
    input  logic [obj_pkg::obj_aw:0]    addr1,
    input  logic [obj_pkg::obj_dw-1:0]  data1,
    input  logic                        we1,
    output logic [obj_pkg::obj_dw-1:0]  q1
);
    import obj_pkg::*;

    // Two halves of 256 words each, MSB of the address picks the half
    logic [obj_dw-1:0] mem [0:(2**(obj_aw+1))-1];

    always_ff @(posedge clk) begin
        // Sprite pixel writes
        if (we0) begin
            mem[addr0] <= data0;
        end
        // Erase writes
        if (we1) begin
            mem[addr1] <= data1;
        end
        // Read before write on port 1
        q1 <= mem[addr1];
    end

endmodule

// File: rtl/obj_draw.sv
// Draw stage, one sprite row of eight 4-bit pixels per request
// A request is taken only while busy is low
// busy then stays high for exactly 8 clocks, one pixel per clock
// Transparent pixels (index 15) are skipped, their slot is not written
// x + k wraps modulo 256, no clipping at the line edge

`timescale 1ns/10ps

module obj_draw (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                obj_valid,
    input  logic [obj_pkg::obj_aw-1:0]          obj_x,
    input  logic [3:0]                          obj_pal,
    input  logic [4*obj_pkg::obj_row_pixels-1:0] obj_pixels,
    input  logic                                obj_hflip,
    output logic                                busy,
    output logic                                we,
    output logic [obj_pkg::obj_aw-1:0]          wr_addr,
    output logic [obj_pkg::obj_dw-1:0]          wr_data
);
    import obj_pkg::*;

    obj_draw_state_t state;

    // Pixel position within the row
    logic [2:0] cnt;

    // Latched request
    logic [obj_aw-1:0]           x_q;
    logic [3:0]                  pal_q;
    logic [4*obj_row_pixels-1:0] pixels_q;
    logic                        hflip_q;

    // Nibble selected for the current position
    logic [2:0] idx;
    logic [3:0] nibble;

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= draw_idle;
            cnt   <= 3'd0;
        end else begin
            case (state)
                draw_idle: begin
                    if (obj_valid) begin
                        state <= draw_busy;
                        cnt   <= 3'd0;
                    end
                end
                draw_busy: begin
                    cnt <= cnt + 3'd1;
                    // Last pixel of the row
                    if (cnt == 3'(obj_row_pixels - 1)) begin
                        state <= draw_idle;
                    end
                end
                default: begin
                    state <= draw_idle;
                end
            endcase
        end
    end

    // Request payload, captured on an accepted strobe
    always_ff @(posedge clk) begin
        if (state == draw_idle && obj_valid) begin
            x_q      <= obj_x;
            pal_q    <= obj_pal;
            pixels_q <= obj_pixels;
            hflip_q  <= obj_hflip;
        end
    end

    assign busy = (state == draw_busy);

    // Mirrored rows walk the nibbles from pixel 7 down to pixel 0
    assign idx    = hflip_q ? ~cnt : cnt;
    assign nibble = pixels_q[{idx, 2'b00} +: 4];

    // Address wraps naturally at 8 bits
    assign wr_addr = x_q + obj_aw'(cnt);
    assign wr_data = {pal_q, nibble};

    // Only place where transparency is tested
    assign we = busy && (nibble != obj_alpha);

endmodule

// File: rtl/obj_line_buffer.sv
// Double line buffer, one half drawn while the other is scanned out
// Halves swap on the clock after lhbl falls
// Every read erases its slot one clock later with the blank word
// Reads must come at most every second clock, the erase uses the free slot
// flip mirrors write addresses only (255 - address)

`timescale 1ns/10ps

module obj_line_buffer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        lhbl,
    input  logic                        flip,
    input  logic                        we,
    input  logic [obj_pkg::obj_aw-1:0]  wr_addr,
    input  logic [obj_pkg::obj_dw-1:0]  wr_data,
    input  logic                        rd,
    input  logic [obj_pkg::obj_aw-1:0]  rd_addr,
    output logic [obj_pkg::obj_dw-1:0]  pixel,
    output logic                        pixel_valid
);
    import obj_pkg::*;

    // Half being drawn, the other one is scanned
    logic line_sel;
    logic last_lhbl;

    // Write address after screen flip
    logic [obj_aw-1:0] wr_af;

    // Slot read on the previous clock, erased now
    logic [obj_aw:0] erase_addr;

    // Port 1 address, read or erase
    logic [obj_aw:0] addr1;

    // Blanking edge and half swap
    always_ff @(posedge clk) begin
        if (reset) begin
            line_sel  <= 1'b0;
            last_lhbl <= 1'b1;
        end else begin
            last_lhbl <= lhbl;
            if (last_lhbl && !lhbl) begin
                line_sel <= ~line_sel;
            end
        end
    end

    // pixel_valid doubles as the erase strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            erase_addr <= {~line_sel, rd_addr};
        end
    end

    // 255 - a is the bitwise inverse for 8 bits
    assign wr_af = flip ? ~wr_addr : wr_addr;

    // Read and erase never share a clock
    assign addr1 = rd ? {~line_sel, rd_addr} : erase_addr;

    obj_dual_ram obj_dual_ram_inst (
        .clk   (clk),
        .addr0 ({line_sel, wr_af}),
        .data0 (wr_data),
        .we0   (we),
        .addr1 (addr1),
        .data1 (obj_blank),
        .we1   (pixel_valid),
        .q1    (pixel)
    );

endmodule

// File: rtl/obj_scan.sv
// Horizontal scan timing for the line buffer read side
// pxl_cen is high on every second clock, a line is 320 slots (640 clocks)
// Active video is hcount 0 to 255, blanking is 256 to 319
// No vertical timing here

`timescale 1ns/10ps

module obj_scan (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        pxl_cen,
    output logic [8:0]                  hcount,
    output logic                        lhbl,
    output logic                        rd,
    output logic [obj_pkg::obj_aw-1:0]  rd_addr
);
    import obj_pkg::*;

    // Divide by two for the pixel enable
    always_ff @(posedge clk) begin
        if (reset) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Pixel slot counter
    always_ff @(posedge clk) begin
        if (reset) begin
            hcount <= 9'd0;
        end else if (pxl_cen) begin
            if (hcount == 9'(obj_h_total - 1)) begin
                hcount <= 9'd0;
            end else begin
                hcount <= hcount + 9'd1;
            end
        end
    end

    // High during the visible part of the line
    assign lhbl = (hcount < 9'(obj_h_active));

    // One read per visible pixel slot
    assign rd      = pxl_cen && lhbl;
    assign rd_addr = hcount[obj_aw-1:0];

endmodule

// File: rtl/obj_render_top.sv
// Sprite line renderer, draw stage -> line buffer -> scan stage
// Sprite rows drawn during line n are shown in line n+1
// The source must keep obj_valid low while busy is high
// pixel arrives 1 clock after its read slot, with pixel_valid

`timescale 1ns/10ps

module obj_render_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 flip,
    input  logic                                 obj_valid,
    input  logic [obj_pkg::obj_aw-1:0]           obj_x,
    input  logic [3:0]                           obj_pal,
    input  logic [4*obj_pkg::obj_row_pixels-1:0] obj_pixels,
    input  logic                                 obj_hflip,
    output logic                                 busy,
    output logic                                 lhbl,
    output logic [8:0]                           hcount,
    output logic [obj_pkg::obj_dw-1:0]           pixel,
    output logic                                 pixel_valid
);
    import obj_pkg::*;

    // Draw side writes
    logic              we;
    logic [obj_aw-1:0] wr_addr;
    logic [obj_dw-1:0] wr_data;

    // Scan side reads
    logic              rd;
    logic [obj_aw-1:0] rd_addr;

    obj_draw obj_draw_inst (
        .clk        (clk),
        .reset      (reset),
        .obj_valid  (obj_valid),
        .obj_x      (obj_x),
        .obj_pal    (obj_pal),
        .obj_pixels (obj_pixels),
        .obj_hflip  (obj_hflip),
        .busy       (busy),
        .we         (we),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    obj_line_buffer obj_line_buffer_inst (
        .clk         (clk),
        .reset       (reset),
        .lhbl        (lhbl),
        .flip        (flip),
        .we          (we),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd          (rd),
        .rd_addr     (rd_addr),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    // Pixel enable is already folded into rd
    obj_scan obj_scan_inst (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (),
        .hcount  (hcount),
        .lhbl    (lhbl),
        .rd      (rd),
        .rd_addr (rd_addr)
    );

endmodule

// File: test/obj_render_assertions.sv
// Protocol checks on the sprite renderer top level, attached with bind
// Reports only through failing assertions
// The testbench polls the failure count
// Assumes the pixel clock enable runs on every second clock

`timescale 1ns/10ps

module obj_render_assertions (
    input logic clk,
    input logic reset,
    input logic obj_valid,
    input logic busy,
    input logic lhbl,
    input logic pixel_valid
);

    // Failed assertions so far
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // Source must hold off while a row is being drawn
    assert property (@(posedge clk) disable iff (reset)
        busy |-> !obj_valid)
        else begin
            $error("obj_valid asserted while the draw stage is busy");
            fail_count++;
        end

    // Last pixel may trail the blanking edge by one clock, never two
    assert property (@(posedge clk) disable iff (reset)
        (!lhbl && !$past(lhbl)) |-> !pixel_valid)
        else begin
            $error("pixel_valid seen deep inside horizontal blanking");
            fail_count++;
        end

    // One row is exactly eight pixel clocks of drawing
    assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> busy [*8] ##1 !busy)
        else begin
            $error("busy did not last exactly 8 cycles");
            fail_count++;
        end

    // Reads come every second clock, so valid is a single pulse
    assert property (@(posedge clk) disable iff (reset)
        pixel_valid |=> !pixel_valid)
        else begin
            $error("pixel_valid held for more than one cycle");
            fail_count++;
        end

endmodule

// File: test/obj_render_tb.sv
// Testbench for the sprite line renderer
// Replays sprite requests per line from the pattern file
// Expected pixels come from a per-line model of the drawing rules
// Lines 0 and 1 read RAM that was never erased, checks start at line 2
// Content drawn in line n is expected in line n+1 only

`timescale 1ns/10ps

module obj_render_tb;
    import obj_pkg::*;

    localparam int max_req     = 64;
    localparam int max_lines   = 32;
    localparam int line_clocks = 2 * obj_h_total;

    logic        clk;
    logic        reset;
    logic        flip;
    logic        obj_valid;
    logic [7:0]  obj_x;
    logic [3:0]  obj_pal;
    logic [31:0] obj_pixels;
    logic        obj_hflip;
    logic        busy;
    logic        lhbl;
    logic [8:0]  hcount;
    logic [7:0]  pixel;
    logic        pixel_valid;

    // Raw words from the pattern file, six per request
    logic [31:0] pat_mem [0:6*max_req-1];

    // Decoded requests
    int          req_line   [0:max_req-1];
    logic        req_flip   [0:max_req-1];
    logic [7:0]  req_x      [0:max_req-1];
    logic [3:0]  req_pal    [0:max_req-1];
    logic        req_hflip  [0:max_req-1];
    logic [31:0] req_pixels [0:max_req-1];

    // Screen flip per line and the expected buffer contents per line
    logic        line_flip [0:max_lines-1];
    logic [7:0]  model     [0:max_lines-1][0:255];

    int          num_req;
    int          num_lines;
    int          timeout_limit;
    int          cycles;
    int          scan_line;
    int          pv_count;
    int          scan_clocks;
    int          exp_hcount;
    logic        last_lhbl_seen;
    logic [7:0]  exp_pix;

    obj_render_top obj_render_top_inst (
        .clk         (clk),
        .reset       (reset),
        .flip        (flip),
        .obj_valid   (obj_valid),
        .obj_x       (obj_x),
        .obj_pal     (obj_pal),
        .obj_pixels  (obj_pixels),
        .obj_hflip   (obj_hflip),
        .busy        (busy),
        .lhbl        (lhbl),
        .hcount      (hcount),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    bind obj_render_top obj_render_assertions obj_render_assertions_inst (
        .clk         (clk),
        .reset       (reset),
        .obj_valid   (obj_valid),
        .busy        (busy),
        .lhbl        (lhbl),
        .pixel_valid (pixel_valid)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    task automatic load_patterns;
        int   base;
        logic done;
        $readmemh("test/obj_render_patterns.hex", pat_mem);
        num_req   = 0;
        num_lines = 0;
        done      = 1'b0;
        // Line FF or an unfilled word ends the list
        while (!done && num_req < max_req) begin
            base = 6 * num_req;
            if (pat_mem[base] === 32'hff || $isunknown(pat_mem[base])) begin
                done = 1'b1;
            end else begin
                req_line[num_req]   = int'(pat_mem[base]);
                req_flip[num_req]   = pat_mem[base+1][0];
                req_x[num_req]      = pat_mem[base+2][7:0];
                req_pal[num_req]    = pat_mem[base+3][3:0];
                req_hflip[num_req]  = pat_mem[base+4][0];
                req_pixels[num_req] = pat_mem[base+5];
                if (req_line[num_req] + 1 < num_lines) begin
                    $display("Pattern file lists its lines out of order");
                    $display("SIMULATION FAILED");
                    $fatal(1, "bad pattern order");
                end
                num_lines = req_line[num_req] + 1;
                num_req++;
            end
        end
        if (num_lines > max_lines - 3) begin
            $display("Pattern file uses more lines than the model can hold");
            $display("SIMULATION FAILED");
            $fatal(1, "pattern file too long");
        end
    endtask

    // Expected contents of each line half, later requests overwrite
    task automatic build_model;
        int         src;
        int         pos;
        logic [3:0] nib;
        for (int l = 0; l < max_lines; l++) begin
            line_flip[l] = 1'b0;
            for (int a = 0; a < 256; a++) begin
                model[l][a] = obj_blank;
            end
        end
        for (int r = 0; r < num_req; r++) begin
            line_flip[req_line[r]] = req_flip[r];
            for (int k = 0; k < obj_row_pixels; k++) begin
                // Mirrored rows place pixel 7 first
                src = req_hflip[r] ? obj_row_pixels - 1 - k : k;
                nib = req_pixels[r][4*src +: 4];
                if (nib != obj_alpha) begin
                    pos = (int'(req_x[r]) + k) % 256;
                    if (req_flip[r]) begin
                        pos = 255 - pos;
                    end
                    model[req_line[r]][pos] = {req_pal[r], nib};
                end
            end
        end
    endtask

    function automatic logic [7:0] expected_pixel(input int line, input int slot);
        if (line < max_lines) begin
            return model[line][slot];
        end
        return obj_blank;
    endfunction

    // Step to the first clock of the next line
    task automatic wait_line_start;
        do begin
            @(posedge clk);
            #1;
        end while (hcount != 9'(obj_h_total - 1));
        do begin
            @(posedge clk);
            #1;
        end while (hcount != 9'd0);
    endtask

    task automatic send_request(input int r);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        obj_valid  = 1'b1;
        obj_x      = req_x[r];
        obj_pal    = req_pal[r];
        obj_pixels = req_pixels[r];
        obj_hflip  = req_hflip[r];
        @(posedge clk);
        #1;
        obj_valid  = 1'b0;
        // Draw stage takes the row on the strobe clock
        assert (busy === 1'b1) else begin
            $display("[ERROR] %0t: busy low after request %0d, expected high", $time, r);
            $display("SIMULATION FAILED");
            $fatal(1, "busy mismatch");
        end
    endtask

    initial begin : main_flow
        int n;
        int r;
        clk            = 1'b0;
        reset          = 1'b1;
        flip           = 1'b0;
        obj_valid      = 1'b0;
        obj_x          = 8'd0;
        obj_pal        = 4'd0;
        obj_pixels     = 32'd0;
        obj_hflip      = 1'b0;
        cycles         = 0;
        timeout_limit  = 0;
        scan_line      = 0;
        pv_count       = 0;
        scan_clocks    = 0;
        exp_hcount     = 0;
        last_lhbl_seen = 1'b1;
        load_patterns();
        build_model();
        timeout_limit = (num_lines + 3) * line_clocks + 100;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        // Replay, each line's requests start at hcount 0
        r = 0;
        for (n = 0; n < num_lines; n++) begin
            if (n > 0) begin
                wait_line_start();
            end
            flip = line_flip[n];
            while (r < num_req && req_line[r] == n) begin
                send_request(r);
                r++;
            end
        end
        // Two more lines show the last content and then its erasure
        while (scan_line < num_lines + 2) begin
            @(posedge clk);
        end
        if (obj_render_top_inst.obj_render_assertions_inst.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("A protocol assertion in the bound checker failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // Output checks at the falling edge, away from the register updates
    always @(negedge clk) begin
        if (reset) begin
            pv_count       = 0;
            scan_line      = 0;
            scan_clocks    = 0;
            last_lhbl_seen = 1'b1;
        end else begin
            // Slot counter steps on every second clock and wraps at the line length
            exp_hcount = (scan_clocks / 2) % obj_h_total;
            assert (hcount === 9'(exp_hcount) && lhbl === (exp_hcount < obj_h_active)) else begin
                $display("[ERROR] %0t: hcount %0d lhbl %b, expected %0d and %b",
                         $time, hcount, lhbl, exp_hcount, exp_hcount < obj_h_active);
                $display("SIMULATION FAILED");
                $fatal(1, "scan timing mismatch");
            end
            scan_clocks++;
            if (pixel_valid) begin
                if (scan_line >= 2) begin
                    exp_pix = expected_pixel(scan_line - 1, pv_count);
                    assert (pixel === exp_pix) else begin
                        $display("[ERROR] %0t: line %0d slot %0d pixel %h, expected %h",
                                 $time, scan_line, pv_count, pixel, exp_pix);
                        $display("SIMULATION FAILED");
                        $fatal(1, "pixel mismatch");
                    end
                end
                pv_count++;
            end
            // Last pixel of a line shows up together with the blanking edge
            if (last_lhbl_seen && !lhbl) begin
                assert (pv_count == obj_h_active) else begin
                    $display("[ERROR] %0t: line %0d gave %0d pixels, expected %0d",
                             $time, scan_line, pv_count, obj_h_active);
                    $display("SIMULATION FAILED");
                    $fatal(1, "pixel count mismatch");
                end
                scan_line++;
                pv_count = 0;
            end
            last_lhbl_seen = lhbl;
        end
    end

    // A failed protocol assertion ends the run at the next clock
    always @(posedge clk) begin
        if (obj_render_top_inst.obj_render_assertions_inst.fail_count != 0) begin
            $display("A protocol assertion in the bound checker failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            $display("The run timed out after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

// File: test/obj_render_patterns.hex
// Columns: line flip x palette hflip pixels (pixel 0 in the low nibble)
// One sprite request per row, in replay order, line FF ends the list
// Lines 0, 2, 3 and 7 have no requests and must scan out blank
// Line 1: mixed opaque and transparent pixels
01 0 0A 3 0 7F65F32F
01 0 64 4 0 76543210
01 0 C8 9 0 FFFF1FFF
// Line 4: mirrored rows and wrap past slot 255
04 0 28 5 1 0123F567
04 0 FC 6 0 89ABCDE1
04 0 80 A 1 F1E2D3C4
// Line 5: overlap, later opaque pixels win
05 0 3C 1 0 87654321
05 0 3F 2 0 F2F2F2F2
05 0 42 B 1 FFF0FFF0
05 0 3A C 0 111FFFFF
// Line 6: screen flip, plain, mirrored and wrapping rows
06 1 00 7 0 1234F678
06 1 C8 8 1 ABCDEF01
06 1 FA D 0 FEDCBA98
// Line 8: a fully transparent row and a checkered row
08 0 14 E 0 FFFFFFFF
08 0 80 F 0 0F0F0F0F
// Line 9: mirrored row starting at the last slot
09 0 FF 2 1 13579BDF
// Line 10: screen flip with overlap
0A 1 10 3 0 55555555
0A 1 12 4 1 F6F6F6F6
0A 1 FE 5 1 7777FFFF
// Line 11: eight rows side by side at the left of the line
0B 0 00 1 0 01234567
0B 0 08 2 1 89ABCDE0
0B 0 10 3 0 F1F1F1F1
0B 0 18 4 0 2F2F2F2F
0B 0 20 5 1 3456789A
0B 0 28 6 0 BCDE0123
0B 0 30 7 1 FFFFFFF4
0B 0 38 8 0 5FFFFFFF
// End marker
FF 0 00 0 0 00000000

// File: obj_render.f
rtl/obj_pkg.sv
rtl/obj_dual_ram.sv
rtl/obj_draw.sv
rtl/obj_line_buffer.sv
rtl/obj_scan.sv
rtl/obj_render_top.sv
test/obj_render_assertions.sv
test/obj_render_tb.sv
